// File: hdl/div_params.svh
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand and result width, 8 and 16 also work
`define DIV_WIDTH 32

// shift-and-subtract steps per cycle
`define DIV_STEPS 4

`endif

// File: hdl/div_op_pkg.sv
package div_op_pkg;

  // opcodes at the unit boundary
  typedef enum logic [1:0] {
    OP_DIVU = 2'd0,
    OP_DIV  = 2'd1,
    OP_REMU = 2'd2,
    OP_REM  = 2'd3
  } div_op_e;

endpackage

// File: hdl/div_ctrl_pkg.sv
package div_ctrl_pkg;

  typedef enum logic [1:0] {
    DIV_IDLE    = 2'd0,
    DIV_WORKING = 2'd1,
    DIV_PRINT   = 2'd2
  } div_state_e;

  // special-case class from decode
  typedef enum logic [1:0] {
    SPEC_NONE = 2'd0,
    SPEC_ZERO = 2'd1,
    SPEC_OVF  = 2'd2
  } div_special_e;

endpackage

// File: hdl/div_ifs.sv
`timescale 1ns/1ns
`include "div_params.svh"

// decoded operands, decode to iterate
interface div_operand_if;
  import div_ctrl_pkg::*;

  logic                  valid;
  div_special_e          special;
  logic [`DIV_WIDTH-1:0] dividend_mag;
  logic [`DIV_WIDTH-1:0] divisor_mag;
  logic                  q_neg;
  logic                  r_neg;
  logic                  rem_sel;
  logic [`DIV_WIDTH-1:0] raw_dividend;

  modport src (
    output valid, special, dividend_mag, divisor_mag,
    output q_neg, r_neg, rem_sel, raw_dividend
  );
  modport dst (
    input valid, special, dividend_mag, divisor_mag,
    input q_neg, r_neg, rem_sel, raw_dividend
  );
endinterface

// unsigned results plus sign info, iterate to result
interface div_raw_if;
  logic                  done;
  logic [`DIV_WIDTH-1:0] quotient_mag;
  logic [`DIV_WIDTH-1:0] remainder_mag;
  logic                  q_neg;
  logic                  r_neg;
  logic                  rem_sel;

  modport src (output done, quotient_mag, remainder_mag, q_neg, r_neg, rem_sel);
  modport dst (input done, quotient_mag, remainder_mag, q_neg, r_neg, rem_sel);
endinterface

// File: hdl/div_decode.sv
`timescale 1ns/1ns
`include "div_params.svh"

module div_decode (
  input  div_op_pkg::div_op_e   op,
  input  logic                  div_valid,
  input  logic [`DIV_WIDTH-1:0] src2_dividend,
  input  logic [`DIV_WIDTH-1:0] src1_divisor,
  div_operand_if.src            opif
);
  import div_op_pkg::*;
  import div_ctrl_pkg::*;

  localparam int W = `DIV_WIDTH;

  logic         is_signed;
  logic         a_neg;
  logic         b_neg;
  logic [W-1:0] most_neg;

  assign is_signed = (op == OP_DIV) || (op == OP_REM);
  assign most_neg  = {1'b1, {(W-1){1'b0}}};

  // sign bits only count for signed opcodes
  assign a_neg = is_signed & src2_dividend[W-1];
  assign b_neg = is_signed & src1_divisor[W-1];

  always_comb begin
    if (src1_divisor == '0) begin
      opif.special = SPEC_ZERO;
    end else if (is_signed && (src2_dividend == most_neg) && (src1_divisor == '1)) begin
      opif.special = SPEC_OVF;
    end else begin
      opif.special = SPEC_NONE;
    end
  end

  // two's complement magnitudes
  assign opif.dividend_mag = a_neg ? (~src2_dividend + 1'b1) : src2_dividend;
  assign opif.divisor_mag  = b_neg ? (~src1_divisor + 1'b1) : src1_divisor;

  assign opif.valid        = div_valid;
  assign opif.q_neg        = a_neg ^ b_neg;
  // remainder follows the dividend
  assign opif.r_neg        = a_neg;
  assign opif.rem_sel      = (op == OP_REMU) || (op == OP_REM);
  assign opif.raw_dividend = src2_dividend;

endmodule

// File: hdl/div_iterate.sv
`timescale 1ns/1ns
`include "div_params.svh"

module div_iterate (
  input  logic       clk,
  input  logic       rst_n,
  div_operand_if.dst opif,
  div_raw_if.src     rawif,
  input  logic       result_ready
);
  import div_ctrl_pkg::*;

  localparam int W  = `DIV_WIDTH;
  localparam int CW = $clog2(W) + 1;
  localparam int NS = `DIV_STEPS;

  div_state_e    state;
  div_state_e    next_state;

  logic [W-1:0]  dividend_q;
  logic [W-1:0]  divisor_q;
  logic [W-1:0]  quotient_q;
  logic [W-1:0]  remainder_q;
  logic [CW-1:0] count_q;
  logic          q_neg_q;
  logic          r_neg_q;
  logic          rem_sel_q;

  logic [W-1:0]  dividend_d;
  logic [W-1:0]  divisor_d;
  logic [W-1:0]  quotient_d;
  logic [W-1:0]  remainder_d;
  logic [CW-1:0] count_d;
  logic          q_neg_d;
  logic          r_neg_d;
  logic          load_ops;
  logic          load_res;
  logic          accept;
  logic          reuse;

  logic [CW-1:0] clz;
  logic [CW-1:0] count_init;
  logic [W-1:0]  q_step [NS+1];
  logic [W-1:0]  r_step [NS+1];
  logic [W-1:0]  step_q;
  logic [W-1:0]  step_r;
  logic [CW-1:0] step_cnt;

  // ripple scan from the msb
  function automatic logic [CW-1:0] lead_zeros(input logic [W-1:0] v);
    logic [CW-1:0] n;
    logic          found;
    n     = '0;
    found = 1'b0;
    for (int i = W - 1; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n = n + 1'b1;
      end
    end
    return n;
  endfunction

  // one restoring step, returns {remainder, quotient}
  function automatic logic [2*W-1:0] div_step(
    input logic [W-1:0] r,
    input logic [W-1:0] q,
    input logic [W-1:0] d
  );
    logic [W:0]   shifted;
    logic [W+1:0] diff;
    shifted = {r, q[W-1]};
    diff    = {1'b0, shifted} - {2'b00, d};
    if (diff[W+1]) begin
      return {shifted[W-1:0], q[W-2:0], 1'b0};
    end
    return {diff[W-1:0], q[W-2:0], 1'b1};
  endfunction

  assign clz        = lead_zeros(opif.dividend_mag);
  assign count_init = CW'(W + 1) - clz;
  assign accept     = (state == DIV_IDLE) && opif.valid;

  assign reuse = (opif.special == SPEC_NONE) &&
                 (opif.dividend_mag == dividend_q) && (opif.divisor_mag == divisor_q) &&
                 (opif.q_neg == q_neg_q) && (opif.r_neg == r_neg_q);

  // four steps chained, early exit picks the step where the count hits one
  always_comb begin
    q_step[0] = quotient_q;
    r_step[0] = remainder_q;
    for (int i = 0; i < NS; i++) begin
      {r_step[i+1], q_step[i+1]} = div_step(r_step[i], q_step[i], divisor_q);
    end
    step_q   = q_step[NS];
    step_r   = r_step[NS];
    step_cnt = count_q - CW'(NS);
    for (int k = 1; k < NS; k++) begin
      if (count_q == CW'(k + 1)) begin
        step_q   = q_step[k];
        step_r   = r_step[k];
        step_cnt = CW'(1);
      end
    end
  end

  always_comb begin
    next_state  = state;
    load_ops    = 1'b0;
    load_res    = 1'b0;
    dividend_d  = opif.dividend_mag;
    divisor_d   = opif.divisor_mag;
    q_neg_d     = opif.q_neg;
    r_neg_d     = opif.r_neg;
    quotient_d  = step_q;
    remainder_d = step_r;
    count_d     = step_cnt;
    case (state)
      DIV_IDLE: begin
        if (opif.valid) begin
          if (opif.special != SPEC_NONE) begin
            // clear stored operands so nothing reuses a special result
            load_ops    = 1'b1;
            load_res    = 1'b1;
            dividend_d  = '0;
            divisor_d   = '0;
            q_neg_d     = 1'b0;
            r_neg_d     = 1'b0;
            count_d     = CW'(1);
            quotient_d  = (opif.special == SPEC_ZERO) ? '1 : {1'b1, {(W-1){1'b0}}};
            remainder_d = (opif.special == SPEC_ZERO) ? opif.raw_dividend : '0;
            next_state  = DIV_PRINT;
          end else if (reuse) begin
            next_state = DIV_PRINT;
          end else begin
            load_ops    = 1'b1;
            load_res    = 1'b1;
            quotient_d  = opif.dividend_mag << clz;
            remainder_d = '0;
            count_d     = count_init;
            next_state  = (count_init == CW'(1)) ? DIV_PRINT : DIV_WORKING;
          end
        end
      end
      DIV_WORKING: begin
        load_res   = 1'b1;
        next_state = (step_cnt == CW'(1)) ? DIV_PRINT : DIV_WORKING;
      end
      DIV_PRINT: begin
        if (result_ready) begin
          next_state = DIV_IDLE;
        end
      end
      default: next_state = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= DIV_IDLE;
      dividend_q <= '0;
      divisor_q  <= '0;
      q_neg_q    <= 1'b0;
      r_neg_q    <= 1'b0;
      count_q    <= '0;
      rem_sel_q  <= 1'b0;
    end else begin
      state <= next_state;
      if (load_ops) begin
        dividend_q <= dividend_d;
        divisor_q  <= divisor_d;
        q_neg_q    <= q_neg_d;
        r_neg_q    <= r_neg_d;
      end
      if (load_res) begin
        count_q <= count_d;
      end
      if (accept) begin
        rem_sel_q <= opif.rem_sel;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_res) begin
      quotient_q  <= quotient_d;
      remainder_q <= remainder_d;
    end
  end

  assign rawif.done          = (state == DIV_PRINT);
  assign rawif.quotient_mag  = quotient_q;
  assign rawif.remainder_mag = remainder_q;
  assign rawif.q_neg         = q_neg_q;
  assign rawif.r_neg         = r_neg_q;
  assign rawif.rem_sel       = rem_sel_q;

endmodule

// File: hdl/div_result.sv
`timescale 1ns/1ns
`include "div_params.svh"

module div_result (
  div_raw_if.dst                rawif,
  output logic [`DIV_WIDTH-1:0] result,
  output logic                  result_valid
);

  localparam int W = `DIV_WIDTH;

  logic [W-1:0] quotient;
  logic [W-1:0] remainder;

  // put the signs back
  assign quotient  = rawif.q_neg ? (~rawif.quotient_mag + 1'b1) : rawif.quotient_mag;
  assign remainder = rawif.r_neg ? (~rawif.remainder_mag + 1'b1) : rawif.remainder_mag;

  always_comb begin
    if (!rawif.done) begin
      result = '0;
    end else if (rawif.rem_sel) begin
      result = remainder;
    end else begin
      result = quotient;
    end
  end

  assign result_valid = rawif.done;

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/1ns
`include "div_params.svh"

module div_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  div_valid,
  input  div_op_pkg::div_op_e   op,
  input  logic [`DIV_WIDTH-1:0] src2_dividend,
  input  logic [`DIV_WIDTH-1:0] src1_divisor,
  input  logic                  result_ready,
  output logic [`DIV_WIDTH-1:0] result,
  output logic                  result_valid
);

  div_operand_if opif ();
  div_raw_if     rawif ();

  // operand classify and sign strip
  div_decode u_decode (
    .op            (op),
    .div_valid     (div_valid),
    .src2_dividend (src2_dividend),
    .src1_divisor  (src1_divisor),
    .opif          (opif.src)
  );

  div_iterate u_iterate (
    .clk          (clk),
    .rst_n        (rst_n),
    .opif         (opif.dst),
    .rawif        (rawif.src),
    .result_ready (result_ready)
  );

  // sign restore and output select
  div_result u_result (
    .rawif        (rawif.dst),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

// File: tests/div_unit_assertions.sv
`timescale 1ns/1ns
`include "div_params.svh"

module div_unit_assertions (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     result_valid,
  input logic                     result_ready,
  input logic [`DIV_WIDTH-1:0]    result,
  input div_ctrl_pkg::div_state_e state
);
  import div_ctrl_pkg::*;

  a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !result_valid)
    else $error("result_valid high while in reset");

  // stalled result must not move
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid && !result_ready |=> result_valid && $stable(result))
    else $error("result changed or dropped while result_ready was low");

  a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
    state inside {DIV_IDLE, DIV_WORKING, DIV_PRINT})
    else $error("iterate FSM in an undefined state");

endmodule

bind div_unit div_unit_assertions u_assertions (
  .clk          (clk),
  .rst_n        (rst_n),
  .result_valid (result_valid),
  .result_ready (result_ready),
  .result       (result),
  .state        (u_iterate.state)
);

// File: tests/tb_div_unit.sv
`timescale 1ns/1ns
`include "div_params.svh"

module tb_div_unit;
  import div_op_pkg::*;

  localparam int W       = `DIV_WIDTH;
  localparam int TIMEOUT = 64;

  logic         clk;
  logic         rst_n;
  logic         div_valid;
  div_op_e      op;
  logic [W-1:0] src2_dividend;
  logic [W-1:0] src1_divisor;
  logic         result_ready;
  logic [W-1:0] result;
  logic         result_valid;

  logic [15:0]  lfsr;
  int           errors;
  int           timeouts;

  div_unit u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .div_valid     (div_valid),
    .op            (op),
    .src2_dividend (src2_dividend),
    .src1_divisor  (src1_divisor),
    .result_ready  (result_ready),
    .result        (result),
    .result_valid  (result_valid)
  );

  always #5 clk = ~clk;

  // taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(input int nbits, output logic [W-1:0] v);
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[W-2:0], lfsr[15]};
    end
  endtask

  // truncating division plus the RISC-V special results
  function automatic logic [W-1:0] expected_result(input div_op_e o, input logic [W-1:0] a,
                                                   input logic [W-1:0] b);
    logic signed [W-1:0] sa;
    logic signed [W-1:0] sb;
    logic                want_rem;
    logic                signed_op;
    sa        = a;
    sb        = b;
    want_rem  = (o == OP_REMU) || (o == OP_REM);
    signed_op = (o == OP_DIV) || (o == OP_REM);
    if (b == '0) return want_rem ? a : '1;
    if (signed_op && (a == {1'b1, {(W-1){1'b0}}}) && (b == '1)) return want_rem ? '0 : a;
    if (signed_op) return want_rem ? sa % sb : sa / sb;
    return want_rem ? a % b : a / b;
  endfunction

  // one cycle to start plus four dividend bits per cycle
  function automatic int expected_latency(input logic [W-1:0] mag);
    int n;
    n = 0;
    for (int i = 0; i < W; i++) begin
      if (mag[i]) n = i + 1;
    end
    return 1 + (n + 3) / 4;
  endfunction

  task automatic check_value(input string name, input logic [W-1:0] expected,
                             input logic [W-1:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic start_op(input div_op_e o, input logic [W-1:0] a, input logic [W-1:0] b);
    @(posedge clk);
    div_valid     <= 1'b1;
    op            <= o;
    src2_dividend <= a;
    src1_divisor  <= b;
  endtask

  // counts edges from the first one that sees div_valid
  task automatic wait_result(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
      seen = result_valid;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: result_valid stayed low for %0d cycles", TIMEOUT);
    end
  endtask

  task automatic accept_result();
    @(posedge clk);
    div_valid <= 1'b0;
    @(negedge clk);
    check_value("result_valid", W'(0), W'(result_valid));
  endtask

  task automatic run_op(input div_op_e o, input logic [W-1:0] a, input logic [W-1:0] b,
                        output int lat);
    start_op(o, a, b);
    wait_result(lat);
    check_value("result", expected_result(o, a, b), result);
    accept_result();
  endtask

  task automatic run_both(input div_op_e oq, input div_op_e orem, input logic [W-1:0] a,
                          input logic [W-1:0] b);
    int lat;
    run_op(oq, a, b, lat);
    run_op(orem, a, b, lat);
  endtask

  task automatic test_unsigned();
    logic [W-1:0] a;
    logic [W-1:0] b;
    run_both(OP_DIVU, OP_REMU, W'(1), W'(1));
    run_both(OP_DIVU, OP_REMU, '1, W'(1));
    run_both(OP_DIVU, OP_REMU, '1, '1);
    run_both(OP_DIVU, OP_REMU, W'(5), '1);
    for (int i = 0; i < 8; i++) begin
      random_word(W, a);
      random_word(W, b);
      run_both(OP_DIVU, OP_REMU, a, b);
    end
  endtask

  task automatic test_signed();
    logic [W-1:0] a;
    logic [W-1:0] b;
    for (int s = 0; s < 4; s++) begin
      run_both(OP_DIV, OP_REM, s[0] ? W'(-7) : W'(7), s[1] ? W'(-2) : W'(2));
      random_word(W - 2, a);
      random_word(W / 2, b);
      b = b | W'(1);
      run_both(OP_DIV, OP_REM, s[0] ? -a : a, s[1] ? -b : b);
    end
  endtask

  task automatic test_special();
    logic [W-1:0] a;
    int           lat;
    random_word(W, a);
    for (int i = 0; i < 4; i++) begin
      run_op(div_op_e'(i), a, '0, lat);
      check_value("latency", W'(1), W'(lat));
      run_op(div_op_e'(i), W'(-5), '0, lat);
      check_value("latency", W'(1), W'(lat));
    end
    // most negative over minus one
    run_op(OP_DIV, {1'b1, {(W-1){1'b0}}}, '1, lat);
    check_value("latency", W'(1), W'(lat));
    run_op(OP_REM, {1'b1, {(W-1){1'b0}}}, '1, lat);
    check_value("latency", W'(1), W'(lat));
  endtask

  task automatic test_latency();
    int           bits [5] = '{0, 1, 5, 16, 32};
    logic [W-1:0] a;
    int           lat;
    for (int i = 0; i < 5; i++) begin
      if (bits[i] <= W) begin
        a = (bits[i] == 0) ? '0 : (W'(1) << (bits[i] - 1));
        run_op(OP_DIVU, a, W'(3), lat);
        check_value("latency", W'(1 + (bits[i] + 3) / 4), W'(lat));
      end
    end
  endtask

  task automatic test_reuse();
    int lat;
    run_op(OP_DIV, W'(-100), W'(7), lat);
    check_value("latency", W'(expected_latency(W'(100))), W'(lat));
    run_op(OP_REM, W'(-100), W'(7), lat);
    check_value("latency", W'(1), W'(lat));
    run_op(OP_DIVU, W'(-100), W'(9), lat);
    check_value("latency", W'(expected_latency(W'(-100))), W'(lat));
  endtask

  task automatic check_holding(input logic [W-1:0] expected);
    check_value("result_valid", W'(1), W'(result_valid));
    check_value("result", expected, result);
  endtask

  task automatic test_backpressure();
    logic [W-1:0] a;
    logic [W-1:0] b;
    logic [W-1:0] hold;
    logic [W-1:0] expected;
    int           lat;
    repeat (2) begin
      random_word(W, a);
      random_word(W / 2, b);
      b = b | W'(1);
      random_word(3, hold);
      expected = expected_result(OP_DIVU, a, b);
      @(posedge clk);
      result_ready <= 1'b0;
      start_op(OP_DIVU, a, b);
      wait_result(lat);
      check_value("latency", W'(expected_latency(a)), W'(lat));
      for (int i = 0; i < 2 + int'(hold); i++) begin
        check_holding(expected);
        @(posedge clk);
        @(negedge clk);
      end
      check_holding(expected);
      @(posedge clk);
      result_ready <= 1'b1;
      @(negedge clk);
      check_holding(expected);
      accept_result();
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    div_valid     = 1'b0;
    op            = OP_DIVU;
    src2_dividend = '0;
    src1_divisor  = '0;
    result_ready  = 1'b1;
    lfsr          = 16'd97;
    errors        = 0;
    timeouts      = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    check_value("result_valid", W'(0), W'(result_valid));
    @(posedge clk);
    rst_n <= 1'b1;
    test_unsigned();
    test_signed();
    test_special();
    test_latency();
    test_reuse();
    test_backpressure();
    $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+hdl
hdl/div_op_pkg.sv
hdl/div_ctrl_pkg.sv
hdl/div_ifs.sv
hdl/div_decode.sv
hdl/div_iterate.sv
hdl/div_result.sv
hdl/div_unit.sv
tests/div_unit_assertions.sv
tests/tb_div_unit.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_div_unit -f sim.f -o tb_div_unit
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_div_unit)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
